/* mul_insn_queue.sv */
////////////////////////////////////////////////////////////
// In-order instruction queue with one read pointer per
// phase; an entry is freed only once it has committed
////////////////////////////////////////////////////////////

`default_nettype none

module mul_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vec_op_pkg::mul_insn_t insn_i,
  input  logic                  insn_valid_i,
  output logic                  insn_ready_o,
  input  logic                  issue_done_i,
  input  logic                  process_done_i,
  input  logic                  commit_done_i,
  output vec_op_pkg::mul_insn_t issue_insn_o,
  output logic                  issue_valid_o,
  output vec_op_pkg::mul_insn_t proc_insn_o,
  output logic                  proc_valid_o,
  output vec_op_pkg::mul_insn_t commit_insn_o,
  output logic                  commit_valid_o
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  localparam int unsigned PntBits = $clog2(InsnQueueDepth);

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [PntBits:0]   cnt_t;

  // Read pointer and pending count of one phase
  typedef struct packed {
    pnt_t pnt;
    cnt_t cnt;
  } phase_t;

  // Count grows on accept, pointer moves when the phase finishes
  function automatic phase_t phase_step(phase_t p, logic add, logic done);
    phase_t n;
    n = p;
    if (done) begin
      n.pnt = p.pnt + pnt_t'(1);
    end
    n.cnt = p.cnt + cnt_t'(add) - cnt_t'(done);
    return n;
  endfunction

  mul_insn_t [InsnQueueDepth-1:0] insn_q;
  pnt_t                           accept_pnt_q;
  phase_t                         issue_q;
  phase_t                         proc_q;
  phase_t                         commit_q;
  logic                           accept;

  // Commit count covers every instruction still held
  assign insn_ready_o = (commit_q.cnt != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i & insn_ready_o;

  assign issue_insn_o   = insn_q[issue_q.pnt];
  assign issue_valid_o  = (issue_q.cnt != '0);
  assign proc_insn_o    = insn_q[proc_q.pnt];
  assign proc_valid_o   = (proc_q.cnt != '0);
  assign commit_insn_o  = insn_q[commit_q.pnt];
  assign commit_valid_o = (commit_q.cnt != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_q      <= '0;
      proc_q       <= '0;
      commit_q     <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + pnt_t'(1);
      end
      issue_q  <= phase_step(issue_q, accept, issue_done_i);
      proc_q   <= phase_step(proc_q, accept, process_done_i);
      commit_q <= phase_step(commit_q, accept, commit_done_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

endmodule

`default_nettype wire

/* mul_issue.sv */
////////////////////////////////////////////////////////////
// Issue stage: waits for all needed operands and the mask,
// then hands one word to the multiplier of the right width
////////////////////////////////////////////////////////////

`default_nettype none

module mul_issue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vec_op_pkg::mul_insn_t    insn_i,
  input  logic                     insn_valid_i,
  input  vec_cfg_pkg::elen_t [2:0] operand_i,
  input  logic [2:0]               operand_valid_i,
  output logic [2:0]               operand_ready_o,
  input  vec_cfg_pkg::strb_t       mask_i,
  input  logic                     mask_valid_i,
  output logic                     mask_ready_o,
  output vec_op_pkg::mul_req_t     mul_req_o,
  output logic [3:0]               mul_valid_o,
  input  logic [3:0]               mul_ready_i,
  output logic                     issue_done_o
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  logic       busy_q;
  vl_t        left_q;
  vl_t        left;
  vl_t        issue_elems;
  logic [2:0] need;
  logic       operands_ok;
  logic       fire;
  elem_word_u scalar_in;
  elem_word_u scalar_rep;

  // A new instruction starts from its full vl
  assign left        = busy_q ? left_q : insn_i.vl;
  assign issue_elems = word_elems(insn_i.vew, left);

  // Operand queues read by this instruction
  assign need[0] = insn_i.use_vs1 & ~insn_i.use_scalar;
  assign need[1] = insn_i.use_vs2;
  assign need[2] = insn_i.use_vd;

  assign operands_ok = insn_valid_i & (&(operand_valid_i | ~need))
                     & (mask_valid_i | insn_i.vm);
  assign fire        = operands_ok & mul_ready_i[insn_i.vew];

  always_comb begin
    mul_valid_o             = '0;
    mul_valid_o[insn_i.vew] = operands_ok;
  end

  // Acknowledge exactly what was consumed
  assign operand_ready_o = fire ? need : 3'b000;
  assign mask_ready_o    = fire & ~insn_i.vm;
  assign issue_done_o    = fire & (left == issue_elems);

  // Scalar copied into every element of the word
  assign scalar_in = insn_i.scalar;

  always_comb begin
    unique case (insn_i.vew)
      EW8:     scalar_rep.b = {8{scalar_in.b[0]}};
      EW16:    scalar_rep.h = {4{scalar_in.h[0]}};
      EW32:    scalar_rep.s = {2{scalar_in.s[0]}};
      default: scalar_rep.d = scalar_in.d;
    endcase
  end

  assign mul_req_o.op   = insn_i.op;
  assign mul_req_o.a    = insn_i.use_scalar ? elen_t'(scalar_rep) : operand_i[0];
  assign mul_req_o.b    = operand_i[1];
  assign mul_req_o.c    = operand_i[2];
  assign mul_req_o.mask = mask_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      left_q <= '0;
    end else if (fire) begin
      busy_q <= ~issue_done_o;
      left_q <= left - issue_elems;
    end
  end

endmodule

`default_nettype wire

/* mul_result_queue.sv */
////////////////////////////////////////////////////////////
// Collects multiplier words in processing order and writes
// them to the register file, flagging finished instructions
////////////////////////////////////////////////////////////

`default_nettype none

module mul_result_queue (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  vec_op_pkg::mul_insn_t            proc_insn_i,
  input  logic                             proc_valid_i,
  input  vec_op_pkg::mul_insn_t            commit_insn_i,
  input  logic                             commit_valid_i,
  input  vec_cfg_pkg::elen_t [3:0]         mul_result_i,
  input  vec_cfg_pkg::strb_t [3:0]         mul_mask_i,
  input  logic [3:0]                       mul_valid_i,
  output logic [3:0]                       mul_ready_o,
  output logic                             process_done_o,
  output logic                             commit_done_o,
  output vec_op_pkg::result_t              result_o,
  output logic                             result_req_o,
  input  logic                             result_gnt_i,
  output logic [vec_cfg_pkg::NrInsnIds-1:0] done_o
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  localparam int unsigned PntBits = $clog2(ResultQueueDepth);

  typedef logic [PntBits:0] cnt_t;

  result_t [ResultQueueDepth-1:0] queue_q;
  logic [PntBits-1:0] wr_pnt_q;
  logic [PntBits-1:0] rd_pnt_q;
  cnt_t               cnt_q;
  logic               full;
  logic               push;
  logic               pop;
  logic               proc_busy_q;
  logic               commit_busy_q;
  vl_t                proc_left_q;
  vl_t                proc_left;
  vl_t                proc_elems;
  vl_t                commit_left_q;
  vl_t                commit_left;
  vl_t                commit_elems;
  logic [StrbBits:0]  tail;
  result_t            entry;

  assign full = (cnt_q == cnt_t'(ResultQueueDepth));
  assign push = proc_valid_i & mul_valid_i[proc_insn_i.vew] & ~full;
  assign pop  = result_req_o & result_gnt_i;

  // Only the multiplier of the processing width is drained
  always_comb begin
    mul_ready_o                  = '0;
    mul_ready_o[proc_insn_i.vew] = proc_valid_i & ~full;
  end

  assign proc_left      = proc_busy_q ? proc_left_q : proc_insn_i.vl;
  assign proc_elems     = word_elems(proc_insn_i.vew, proc_left);
  assign process_done_o = push & (proc_left == proc_elems);

  // One enable per byte of the elements still inside vl
  assign tail = ({{StrbBits{1'b0}}, 1'b1} << (proc_elems << proc_insn_i.vew)) - 1'b1;

  always_comb begin
    entry.id    = proc_insn_i.id;
    entry.addr  = vaddr_t'(proc_insn_i.vd * VregWords)
                + vaddr_t'((proc_insn_i.vl - proc_left) >> (2'd3 - proc_insn_i.vew));
    entry.wdata = mul_result_i[proc_insn_i.vew];
    entry.be    = tail[StrbBits-1:0]
                & (proc_insn_i.vm ? '1 : mul_mask_i[proc_insn_i.vew]);
  end

  assign result_req_o = (cnt_q != '0);
  assign result_o     = queue_q[rd_pnt_q];

  // Commit side counts granted elements of the oldest instruction
  assign commit_left   = commit_busy_q ? commit_left_q : commit_insn_i.vl;
  assign commit_elems  = word_elems(commit_insn_i.vew, commit_left);
  assign commit_done_o = pop & commit_valid_i & (commit_left == commit_elems);

  always_comb begin
    done_o                   = '0;
    done_o[commit_insn_i.id] = commit_done_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      cnt_q         <= '0;
      proc_busy_q   <= 1'b0;
      proc_left_q   <= '0;
      commit_busy_q <= 1'b0;
      commit_left_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
      if (push) begin
        wr_pnt_q    <= wr_pnt_q + 1'b1;
        proc_busy_q <= ~process_done_o;
        proc_left_q <= proc_left - proc_elems;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      if (pop && commit_valid_i) begin
        commit_busy_q <= ~commit_done_o;
        commit_left_q <= commit_left - commit_elems;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_pnt_q] <= entry;
    end
  end

endmodule

`default_nettype wire

/* simd_mul.sv */
////////////////////////////////////////////////////////////
// SIMD integer multiplier for one element width; the mask
// rides along with each word through the stall-able pipe
////////////////////////////////////////////////////////////

`default_nettype none

module simd_mul #(
  parameter vec_cfg_pkg::vew_e ElemWidth = vec_cfg_pkg::EW64,
  parameter int unsigned       NumStages = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vec_op_pkg::mul_req_t req_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output vec_cfg_pkg::elen_t   result_o,
  output vec_cfg_pkg::strb_t   mask_o,
  output logic                 valid_o,
  input  logic                 ready_i
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  localparam int unsigned Ew = 8 << ElemWidth;

  typedef logic [Ew-1:0] el_t;

  typedef struct packed {
    elen_t data;
    strb_t mask;
  } stage_t;

  function automatic el_t elem_mul(mul_op_e op, el_t a, el_t b, el_t c);
    logic signed [2*Ew-1:0] prod_s;
    logic        [2*Ew-1:0] prod_u;
    prod_s = $signed(a) * $signed(b);
    prod_u = a * b;
    unique case (op)
      VMULH:   return prod_s[2*Ew-1:Ew];
      VMULHU:  return prod_u[2*Ew-1:Ew];
      VMACC:   return c + prod_u[Ew-1:0];
      default: return prod_u[Ew-1:0];
    endcase
  endfunction

  elem_word_u            a_u;
  elem_word_u            b_u;
  elem_word_u            c_u;
  elem_word_u            res_u;
  logic  [NumStages-1:0] valid_q;
  stage_t [NumStages-1:0] stage_q;
  logic                  advance;

  assign a_u = req_i.a;
  assign b_u = req_i.b;
  assign c_u = req_i.c;

  if (ElemWidth == EW8) begin : gen_ew8
    for (genvar i = 0; i < 8; i++) begin : gen_elem
      assign res_u.b[i] = elem_mul(req_i.op, a_u.b[i], b_u.b[i], c_u.b[i]);
    end
  end else if (ElemWidth == EW16) begin : gen_ew16
    for (genvar i = 0; i < 4; i++) begin : gen_elem
      assign res_u.h[i] = elem_mul(req_i.op, a_u.h[i], b_u.h[i], c_u.h[i]);
    end
  end else if (ElemWidth == EW32) begin : gen_ew32
    for (genvar i = 0; i < 2; i++) begin : gen_elem
      assign res_u.s[i] = elem_mul(req_i.op, a_u.s[i], b_u.s[i], c_u.s[i]);
    end
  end else begin : gen_ew64
    assign res_u.d[0] = elem_mul(req_i.op, a_u.d[0], b_u.d[0], c_u.d[0]);
  end

  // A stall at the output holds every stage
  assign advance = ready_i | ~valid_q[NumStages-1];
  assign ready_o = advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < NumStages; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_q[0] <= '{data: elen_t'(res_u), mask: req_i.mask};
      for (int s = 1; s < NumStages; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign result_o = stage_q[NumStages-1].data;
  assign mask_o   = stage_q[NumStages-1].mask;
  assign valid_o  = valid_q[NumStages-1];

endmodule

`default_nettype wire

/* tb_vmul_unit.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the vector multiply unit; checks
// every granted register file word against a reference model
////////////////////////////////////////////////////////////

`default_nettype none

module tb_vmul_unit;
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  localparam int unsigned Timeout = 2000;
  localparam logic [31:0] Seed    = 32'h252a_7ec4;

  // One word offered by the operand queues
  typedef struct packed {
    elen_t      a;
    elen_t      b;
    elen_t      c;
    strb_t      mask;
    logic [2:0] need;
    logic       mneed;
  } operand_word_t;

  typedef struct packed {
    result_t r;
    logic    last;
  } exp_word_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  mul_insn_t            insn_i;
  logic                 insn_valid_i;
  logic                 insn_ready_o;
  elen_t [2:0]          operand_i;
  logic [2:0]           operand_valid_i;
  logic [2:0]           operand_ready_o;
  strb_t                mask_i;
  logic                 mask_valid_i;
  logic                 mask_ready_o;
  result_t              result_o;
  logic                 result_req_o;
  logic                 result_gnt_i;
  logic [NrInsnIds-1:0] done_o;

  operand_word_t op_q[$];
  exp_word_t     exp_q[$];
  int            insn_cnt    = 0;
  logic          gaps_on     = 1'b0;
  // Grants given always (0), randomly (1) or withheld (2)
  int            grant_mode  = 0;

  vmul_unit UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // Reference word computed element by element in 128-bit arithmetic
  function automatic elen_t ref_word(mul_op_e op, vew_e vew, elen_t a, elen_t b, elen_t c);
    int           ew;
    logic [63:0]  emask;
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] ec;
    logic [127:0] p;
    elen_t        r;
    ew    = 8 << vew;
    emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    r     = '0;
    for (int i = 0; i < (8 >> vew); i++) begin
      ea = {64'd0, (a >> (i * ew)) & emask};
      eb = {64'd0, (b >> (i * ew)) & emask};
      ec = {64'd0, (c >> (i * ew)) & emask};
      if (op == VMULH && ea[ew-1]) ea = ea | ~{64'd0, emask};
      if (op == VMULH && eb[ew-1]) eb = eb | ~{64'd0, emask};
      p = ea * eb;
      if (op == VMULH || op == VMULHU) p = p >> ew;
      if (op == VMACC) p = p + ec;
      r = r | ((p[63:0] & emask) << (i * ew));
    end
    return r;
  endfunction

  function automatic elen_t replicate(elen_t scalar, vew_e vew);
    int          ew;
    logic [63:0] emask;
    elen_t       r;
    ew    = 8 << vew;
    emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    r     = '0;
    for (int i = 0; i < (8 >> vew); i++) begin
      r = r | ((scalar & emask) << (i * ew));
    end
    return r;
  endfunction

  function automatic strb_t tail_be(int elems, vew_e vew);
    int bytes;
    bytes = elems << vew;
    return (bytes >= 8) ? 8'hff : strb_t'((1 << bytes) - 1);
  endfunction

  function automatic elen_t byte_bits(strb_t be);
    elen_t m;
    for (int i = 0; i < 8; i++) begin
      m[i*8 +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  // Operand queues and grant driven shortly after the clock edge
  initial begin
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      if (op_q.size() != 0 && !(gaps_on && ($urandom % 4) == 0)) begin
        operand_i[0]    = op_q[0].a;
        operand_i[1]    = op_q[0].b;
        operand_i[2]    = op_q[0].c;
        mask_i          = op_q[0].mask;
        operand_valid_i = op_q[0].need;
        mask_valid_i    = op_q[0].mneed;
      end else begin
        operand_valid_i = '0;
        mask_valid_i    = 1'b0;
      end
      result_gnt_i = (grant_mode == 0) || (grant_mode == 1 && ($urandom % 3) != 0);
    end
  end

  // Handshakes sampled mid-cycle where every input is stable
  always @(negedge clk_i) begin
    exp_word_t e;
    if (rst_ni) begin
      if (operand_ready_o != '0 || mask_ready_o) begin
        assert (op_q.size() != 0) else begin
          $display("Operand acknowledged while no operand word was offered");
          stop_run();
        end
        check_val("operand_ready_o", operand_ready_o, op_q[0].need);
        check_val("mask_ready_o", mask_ready_o, op_q[0].mneed);
        void'(op_q.pop_front());
      end
      if (result_req_o && result_gnt_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Result word granted while no result was expected");
          stop_run();
        end
        e = exp_q.pop_front();
        check_val("result_o.id", result_o.id, e.r.id);
        check_val("result_o.addr", result_o.addr, e.r.addr);
        check_val("result_o.be", result_o.be, e.r.be);
        check_val("result_o.wdata", result_o.wdata & byte_bits(e.r.be),
                  e.r.wdata & byte_bits(e.r.be));
        check_val("done_o", done_o, e.last ? (64'd1 << e.r.id) : 64'd0);
      end else begin
        check_val("done_o", done_o, 64'd0);
      end
    end
  end

  // Offers one instruction, queues its operand words and expected results
  task automatic push_insn(input mul_op_e op, input vew_e vew, input int vl, input int vd,
                           input logic vm, input logic use_scalar);
    mul_insn_t     insn;
    operand_word_t w;
    exp_word_t     e;
    elen_t         a_eff;
    int            per;
    int            words;
    int            elems;
    int            cycles;
    insn            = '0;
    insn.op         = op;
    insn.vew        = vew;
    insn.vl         = vl_t'(vl);
    insn.vd         = 3'(vd);
    insn.id         = insn_id_t'(insn_cnt);
    insn.vm         = vm;
    insn.use_scalar = use_scalar;
    insn.scalar     = {$urandom, $urandom};
    insn.use_vs1    = 1'b1;
    insn.use_vs2    = 1'b1;
    insn.use_vd     = (op == VMACC);
    insn_i          = insn;
    insn_valid_i    = 1'b1;
    cycles          = 0;
    @(negedge clk_i);
    while (!insn_ready_o) begin
      cycles++;
      assert (cycles < Timeout) else begin
        $display("Timeout: instruction %0d was never accepted", insn_cnt);
        stop_run();
      end
      @(negedge clk_i);
    end
    per   = 8 >> vew;
    words = (vl + per - 1) / per;
    for (int k = 0; k < words; k++) begin
      w.a     = {$urandom, $urandom};
      w.b     = {$urandom, $urandom};
      w.c     = {$urandom, $urandom};
      w.mask  = vm ? 8'h00 : strb_t'($urandom);
      w.need  = {insn.use_vd, 1'b1, ~use_scalar};
      w.mneed = ~vm;
      op_q.push_back(w);
      elems     = (vl - k * per < per) ? vl - k * per : per;
      a_eff     = use_scalar ? replicate(insn.scalar, vew) : w.a;
      e.r.id    = insn.id;
      e.r.addr  = vaddr_t'(vd * VregWords + k);
      e.r.wdata = ref_word(op, vew, a_eff, w.b, w.c);
      e.r.be    = tail_be(elems, vew) & (vm ? 8'hff : w.mask);
      e.last    = (k == words - 1);
      exp_q.push_back(e);
    end
    insn_cnt++;
    @(posedge clk_i);
    #2;
    insn_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (op_q.size() != 0 || exp_q.size() != 0) begin
      cycles++;
      assert (cycles < Timeout) else begin
        $display("Timeout: %0d result words still pending", exp_q.size());
        stop_run();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic set_modes(input logic gaps, input int grants);
    @(negedge clk_i);
    gaps_on    = gaps;
    grant_mode = grants;
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    check_val("insn_ready_o", insn_ready_o, 64'd1);
    check_val("operand_ready_o", operand_ready_o, 64'd0);
    check_val("mask_ready_o", mask_ready_o, 64'd0);
    check_val("result_req_o", result_req_o, 64'd0);
    check_val("done_o", done_o, 64'd0);
    @(posedge clk_i);
    #2;
  endtask

  // Tail elements in the last word at every width
  task automatic test_vmul_widths();
    int per;
    for (int v = 0; v < 4; v++) begin
      per = 8 >> v;
      push_insn(VMUL, vew_e'(v), 3 * per + per / 2, v + 1, 1'b1, 1'b0);
      wait_drain();
    end
  endtask

  task automatic test_high_scalar();
    for (int v = 0; v < 4; v++) begin
      push_insn(VMULH, vew_e'(v), 2 * (8 >> v), 2, 1'b1, 1'b1);
      push_insn(VMULHU, vew_e'(v), 2 * (8 >> v) - 1, 5, 1'b1, 1'b1);
      wait_drain();
    end
  endtask

  task automatic test_vmacc_masked();
    for (int v = 0; v < 4; v++) begin
      push_insn(VMACC, vew_e'(v), 4 * (8 >> v) - 1, 7 - v, 1'b0, 1'b0);
      wait_drain();
    end
  endtask

  // Grants withheld until the instruction queue is full
  task automatic test_backpressure();
    set_modes(1'b1, 2);
    push_insn(VMUL, EW32, 5, 1, 1'b1, 1'b0);
    push_insn(VMACC, EW8, 19, 2, 1'b0, 1'b0);
    push_insn(VMULHU, EW64, 3, 3, 1'b1, 1'b1);
    push_insn(VMULH, EW16, 10, 4, 1'b0, 1'b0);
    @(negedge clk_i);
    check_val("insn_ready_o", insn_ready_o, 64'd0);
    set_modes(1'b1, 1);
    wait_drain();
    set_modes(1'b0, 0);
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_reset_state();
    test_vmul_widths();
    test_high_scalar();
    test_vmacc_masked();
    test_backpressure();
    @(negedge clk_i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* vec_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// Datapath sizes, element widths and multiplier latencies
// shared by all blocks of the vector multiply unit
////////////////////////////////////////////////////////////

`default_nettype none

package vec_cfg_pkg;

  // Datapath and queue sizes
  localparam int unsigned ElenBits         = 64;
  localparam int unsigned StrbBits         = ElenBits / 8;
  localparam int unsigned VregWords        = 8;
  localparam int unsigned MaxVl            = 64;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned NrInsnIds        = 8;

  // Pipeline depth of each SIMD multiplier
  localparam int unsigned LatMulEw8  = 1;
  localparam int unsigned LatMulEw16 = 1;
  localparam int unsigned LatMulEw32 = 2;
  localparam int unsigned LatMulEw64 = 3;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef logic [ElenBits-1:0]          elen_t;
  typedef logic [StrbBits-1:0]          strb_t;
  typedef logic [$clog2(MaxVl):0]       vl_t;
  typedef logic [5:0]                   vaddr_t;
  typedef logic [$clog2(NrInsnIds)-1:0] insn_id_t;

  // One word split into elements of each width
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] s;
    logic [0:0][63:0] d;
  } elem_word_u;

  // Elements carried by one word, capped by what is left
  function automatic vl_t word_elems(vew_e vew, vl_t left);
    vl_t per_word;
    per_word = vl_t'(StrbBits >> vew);
    return (left < per_word) ? left : per_word;
  endfunction

endpackage

`default_nettype wire

/* vec_op_pkg.sv */
////////////////////////////////////////////////////////////
// Multiply opcodes, instruction format and the payloads
// passed between issue, multipliers and register file
////////////////////////////////////////////////////////////

`default_nettype none

package vec_op_pkg;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULH  = 2'd1,
    VMULHU = 2'd2,
    VMACC  = 2'd3
  } mul_op_e;

  // Instruction as handed over by the sequencer
  typedef struct packed {
    mul_op_e               op;
    vec_cfg_pkg::vew_e     vew;
    vec_cfg_pkg::vl_t      vl;
    logic [2:0]            vd;
    vec_cfg_pkg::insn_id_t id;
    logic                  vm;  // unmasked when set
    logic                  use_scalar;
    vec_cfg_pkg::elen_t    scalar;
    logic                  use_vs1;
    logic                  use_vs2;
    logic                  use_vd;
  } mul_insn_t;

  // One register file write
  typedef struct packed {
    vec_cfg_pkg::insn_id_t id;
    vec_cfg_pkg::vaddr_t   addr;
    vec_cfg_pkg::elen_t    wdata;
    vec_cfg_pkg::strb_t    be;
  } result_t;

  // One word operation for a multiplier
  typedef struct packed {
    mul_op_e            op;
    vec_cfg_pkg::elen_t a;
    vec_cfg_pkg::elen_t b;
    vec_cfg_pkg::elen_t c;
    vec_cfg_pkg::strb_t mask;
  } mul_req_t;

endpackage

`default_nettype wire

/* vlog.f */
vec_cfg_pkg.sv
vec_op_pkg.sv
mul_insn_queue.sv
mul_issue.sv
simd_mul.sv
mul_result_queue.sv
vmul_unit.sv
tb_vmul_unit.sv

/* vmul_unit.sv */
////////////////////////////////////////////////////////////
// Vector lane integer multiply unit: instruction queue,
// issue stage, one multiplier per width and result queue
////////////////////////////////////////////////////////////

`default_nettype none

module vmul_unit (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  vec_op_pkg::mul_insn_t             insn_i,
  input  logic                              insn_valid_i,
  output logic                              insn_ready_o,
  input  vec_cfg_pkg::elen_t [2:0]          operand_i,
  input  logic [2:0]                        operand_valid_i,
  output logic [2:0]                        operand_ready_o,
  input  vec_cfg_pkg::strb_t                mask_i,
  input  logic                              mask_valid_i,
  output logic                              mask_ready_o,
  output vec_op_pkg::result_t               result_o,
  output logic                              result_req_o,
  input  logic                              result_gnt_i,
  output logic [vec_cfg_pkg::NrInsnIds-1:0] done_o
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  mul_insn_t   issue_insn;
  mul_insn_t   proc_insn;
  mul_insn_t   commit_insn;
  logic        issue_valid;
  logic        proc_valid;
  logic        commit_valid;
  logic        issue_done;
  logic        process_done;
  logic        commit_done;
  mul_req_t    mul_req;
  logic [3:0]  mul_in_valid;
  logic [3:0]  mul_in_ready;
  logic [3:0]  mul_out_valid;
  logic [3:0]  mul_out_ready;
  elen_t [3:0] mul_result;
  strb_t [3:0] mul_mask;

  mul_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .insn_valid_i   (insn_valid_i),
    .insn_ready_o   (insn_ready_o),
    .issue_done_i   (issue_done),
    .process_done_i (process_done),
    .commit_done_i  (commit_done),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .proc_insn_o    (proc_insn),
    .proc_valid_o   (proc_valid),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid)
  );

  mul_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .mul_req_o       (mul_req),
    .mul_valid_o     (mul_in_valid),
    .mul_ready_i     (mul_in_ready),
    .issue_done_o    (issue_done)
  );

  // One multiplier per element width, indexed by the width code
  for (genvar w = 0; w < 4; w++) begin : gen_mul
    localparam int unsigned Lat = (w == 0) ? LatMulEw8  :
                                  (w == 1) ? LatMulEw16 :
                                  (w == 2) ? LatMulEw32 : LatMulEw64;

    simd_mul #(
      .ElemWidth (vew_e'(w)),
      .NumStages (Lat)
    ) i_simd_mul (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .req_i    (mul_req),
      .valid_i  (mul_in_valid[w]),
      .ready_o  (mul_in_ready[w]),
      .result_o (mul_result[w]),
      .mask_o   (mul_mask[w]),
      .valid_o  (mul_out_valid[w]),
      .ready_i  (mul_out_ready[w])
    );
  end

  mul_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .proc_insn_i    (proc_insn),
    .proc_valid_i   (proc_valid),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .mul_result_i   (mul_result),
    .mul_mask_i     (mul_mask),
    .mul_valid_i    (mul_out_valid),
    .mul_ready_o    (mul_out_ready),
    .process_done_o (process_done),
    .commit_done_o  (commit_done),
    .result_o       (result_o),
    .result_req_o   (result_req_o),
    .result_gnt_i   (result_gnt_i),
    .done_o         (done_o)
  );

endmodule

`default_nettype wire
